// File: lsuTop.f
+incdir+design
design/lsuPkg.sv
design/memPkg.sv
design/lsuInterfaces.sv
design/reqQueue.sv
design/memRequest.sv
design/memCtrl.sv
design/byteRam.sv
design/lsuTop.sv
tests/clockGen.sv
tests/lsuTop_tb.sv

// File: run.sh
#!/bin/sh
# builds and runs the lsuTop testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f lsuTop.f --top-module lsuTop_tb \
    --Mdir obj_dir -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

// File: tests/lsuTop_tb.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsuTop_tb;
    logic                   clk;
    logic                   rst;
    logic                   reqValid;
    lsuPkg::memOp           reqOp;
    logic [`ADDR_WIDTH-1:0] reqAddr;
    logic [`DATA_WIDTH-1:0] reqData;
    lsuPkg::accessLen       reqLen;
    logic [`TAG_WIDTH-1:0]  reqTag;
    logic                   reqFull;
    logic                   respValid;
    logic [`DATA_WIDTH-1:0] respData;
    logic [`TAG_WIDTH-1:0]  respTag;

    // byte image of what the RAM should hold
    logic [7:0]             model [`RAM_BYTES];
    logic [`DATA_WIDTH-1:0] expData [$];
    logic [`TAG_WIDTH-1:0]  expTag [$];

    int   errors = 0;
    int   testStart = 0;
    int   testsRun = 0;
    int   testsFailed = 0;
    int   issued = 0;
    int   cycles = 0;
    logic sawFull = 1'b0;

    clockGen clkGen (.clk(clk));

    lsuTop DUT (
        .clk       (clk),
        .rst       (rst),
        .reqValid  (reqValid),
        .reqOp     (reqOp),
        .reqAddr   (reqAddr),
        .reqData   (reqData),
        .reqLen    (reqLen),
        .reqTag    (reqTag),
        .reqFull   (reqFull),
        .respValid (respValid),
        .respData  (respData),
        .respTag   (respTag)
    );

    // applies one request to the model, returns the expected response data
    function automatic logic [`DATA_WIDTH-1:0] applyRequest(
        input lsuPkg::memOp op, input logic [`ADDR_WIDTH-1:0] addr,
        input logic [`DATA_WIDTH-1:0] data, input lsuPkg::accessLen len);
        logic [`DATA_WIDTH-1:0] result;
        int                     nBytes;
        int                     a;
        result = '0;
        nBytes = (len == lsuPkg::BYTE) ? 1 : (len == lsuPkg::HALF) ? 2 : 4;
        for (int i = 0; i < nBytes; i++) begin
            a = int'((addr + 32'(i)) % `RAM_BYTES);
            if (op == lsuPkg::STORE) begin
                model[a] = data[8*i +: 8];
            end else begin
                result[8*i +: 8] = model[a];
            end
        end
        return result;
    endfunction

    // fill byte mixes every address bit
    function automatic logic [31:0] fillWord(input int base);
        logic [31:0] word;
        int          a;
        for (int k = 0; k < 4; k++) begin
            a = base + k;
            word[8*k +: 8] = 8'(a ^ (a >> 3) ^ (a >> 8) ^ 8'h5a);
        end
        return word;
    endfunction

    task automatic checkEqual(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at time %0t: %s is 0x%08h, expected 0x%08h",
                     $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic sendRequest(input lsuPkg::memOp op, input logic [31:0] addr,
                               input logic [31:0] data, input lsuPkg::accessLen len,
                               input logic [3:0] tag);
        while (reqFull) begin
            @(posedge clk);
            #1;
        end
        reqValid = 1'b1;
        reqOp    = op;
        reqAddr  = addr;
        reqData  = data;
        reqLen   = len;
        reqTag   = tag;
        expData.push_back(applyRequest(op, addr, data, len));
        expTag.push_back(tag);
        issued++;
        @(posedge clk);
        #1;
        reqValid = 1'b0;
    endtask

    task automatic drain();
        while (expData.size() != 0) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic reportTest(input string name);
        testsRun++;
        if (errors == testStart) begin
            $display("test %0d %s: passed", testsRun, name);
        end else begin
            testsFailed++;
            $display("test %0d %s: failed", testsRun, name);
        end
        testStart = errors;
    endtask

    // response checker, outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (reqFull) begin
                sawFull = 1'b1;
            end
            if (respValid) begin
                if (expData.size() == 0) begin
                    $display("unexpected response with tag %0d at time %0t",
                             respTag, $time);
                    errors++;
                end else begin
                    checkEqual("response data", respData, expData.pop_front());
                    checkEqual("response tag", 32'(respTag), 32'(expTag.pop_front()));
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 200 * (issued + 1)) begin
            $display("timeout after %0d cycles with %0d requests issued", cycles, issued);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        lsuPkg::memOp     rOp;
        lsuPkg::accessLen rLen;
        logic [31:0]      rAddr;
        logic [31:0]      rData;
        logic [3:0]       rTag;
        void'($urandom(69));
        rst      = 1'b1;
        reqValid = 1'b0;
        reqOp    = lsuPkg::LOAD;
        reqAddr  = '0;
        reqData  = '0;
        reqLen   = lsuPkg::BYTE;
        reqTag   = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (20) begin
            @(posedge clk);
            #1;
            checkEqual("idle respValid", 32'(respValid), 32'd0);
            checkEqual("idle reqFull", 32'(reqFull), 32'd0);
        end
        reportTest("idle after reset");

        // every RAM byte gets a known value so later loads are defined
        for (int i = 0; i < `RAM_BYTES / 4; i++) begin
            sendRequest(lsuPkg::STORE, 32'(4 * i), fillWord(4 * i), lsuPkg::WORD, 4'(i));
        end
        drain();
        reportTest("memory fill");

        sendRequest(lsuPkg::STORE, 32'h0000_0040, 32'hcafe_1234, lsuPkg::WORD, 4'd3);
        sendRequest(lsuPkg::LOAD, 32'h0000_0040, 32'h0, lsuPkg::WORD, 4'd4);
        drain();
        reportTest("word store then load");

        sendRequest(lsuPkg::STORE, 32'h0000_0101, 32'h0000_00a5, lsuPkg::BYTE, 4'd1);
        sendRequest(lsuPkg::STORE, 32'h0000_0103, 32'h0000_f00d, lsuPkg::HALF, 4'd2);
        sendRequest(lsuPkg::STORE, 32'h0000_0106, 32'h8765_4321, lsuPkg::WORD, 4'd5);
        sendRequest(lsuPkg::LOAD, 32'h0000_0101, 32'h0, lsuPkg::BYTE, 4'd6);
        sendRequest(lsuPkg::LOAD, 32'h0000_0103, 32'h0, lsuPkg::HALF, 4'd7);
        sendRequest(lsuPkg::LOAD, 32'h0000_0104, 32'h0, lsuPkg::WORD, 4'd8);
        sendRequest(lsuPkg::LOAD, 32'h0000_0107, 32'h0, lsuPkg::HALF, 4'd9);
        // wraps from the top of the RAM back to byte 0
        sendRequest(lsuPkg::LOAD, 32'h1000_03fe, 32'h0, lsuPkg::WORD, 4'd10);
        drain();
        reportTest("mixed widths unaligned");

        // one request goes straight to the request stage, four fill the queue
        sawFull = 1'b0;
        sendRequest(lsuPkg::STORE, 32'h0000_0200, 32'h1122_3344, lsuPkg::WORD, 4'd8);
        sendRequest(lsuPkg::LOAD, 32'h0000_0200, 32'h0, lsuPkg::WORD, 4'd9);
        sendRequest(lsuPkg::STORE, 32'h0000_0201, 32'h0000_00ee, lsuPkg::BYTE, 4'd10);
        sendRequest(lsuPkg::LOAD, 32'h0000_0200, 32'h0, lsuPkg::WORD, 4'd11);
        sendRequest(lsuPkg::LOAD, 32'h0000_03ff, 32'h0, lsuPkg::HALF, 4'd12);
        drain();
        checkEqual("reqFull raised by burst", 32'(sawFull), 32'd1);
        checkEqual("reqFull after drain", 32'(reqFull), 32'd0);
        reportTest("burst fills queue");

        for (int i = 0; i < 200; i++) begin
            rOp   = lsuPkg::memOp'(1'($urandom % 2));
            rAddr = $urandom % 4096;
            rData = $urandom;
            rLen  = lsuPkg::accessLen'(2'($urandom % 3));
            rTag  = 4'($urandom % 16);
            sendRequest(rOp, rAddr, rData, rLen, rTag);
        end
        drain();
        reportTest("random loads and stores");

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: tests/clockGen.sv
`timescale 1ns/1ps

// free-running clock, 8 ns period
module clockGen #(
    parameter int halfPeriodNs = 4
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    always begin
        #(halfPeriodNs) clk = ~clk;
    end

endmodule

// File: design/lsuTop.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsuTop (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   reqValid,
    input  lsuPkg::memOp           reqOp,
    input  logic [`ADDR_WIDTH-1:0] reqAddr,
    input  logic [`DATA_WIDTH-1:0] reqData,
    input  lsuPkg::accessLen       reqLen,
    input  logic [`TAG_WIDTH-1:0]  reqTag,
    output logic                   reqFull,
    output logic                   respValid,
    output logic [`DATA_WIDTH-1:0] respData,
    output logic [`TAG_WIDTH-1:0]  respTag
);
    lsReqIf   issueIf ();
    memBusIf  busIf ();
    ramPortIf ramIf ();

    reqQueue queue (
        .clk      (clk),
        .rst      (rst),
        .reqValid (reqValid),
        .reqOp    (reqOp),
        .reqAddr  (reqAddr),
        .reqData  (reqData),
        .reqLen   (reqLen),
        .reqTag   (reqTag),
        .reqFull  (reqFull),
        .issue    (issueIf)
    );

    memRequest request (
        .clk       (clk),
        .rst       (rst),
        .issue     (issueIf),
        .bus       (busIf),
        .respValid (respValid),
        .respData  (respData),
        .respTag   (respTag)
    );

    memCtrl ctrl (
        .clk (clk),
        .rst (rst),
        .bus (busIf),
        .ram (ramIf)
    );

    byteRam ram (
        .clk  (clk),
        .port (ramIf)
    );

endmodule

// File: design/byteRam.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module byteRam (
    input logic     clk,
    ramPortIf.slave port
);
    logic [7:0] mem [`RAM_BYTES];

    // read returns the old byte on a same-address write
    always_ff @(posedge clk) begin
        if (port.we) begin
            mem[port.addr] <= port.wbyte;
        end
        port.rbyte <= mem[port.addr];
    end

endmodule

// File: design/memCtrl.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module memCtrl (
    input  logic     clk,
    input  logic     rst,
    memBusIf.slave   bus,
    ramPortIf.master ram
);
    memPkg::ctrlState       state;
    memPkg::ramAddr         addrReg;
    logic [2:0]             idx;
    logic [2:0]             nBytes;
    logic [1:0]             lane;
    logic [`DATA_WIDTH-1:0] wdataReg;
    logic [`DATA_WIDTH-1:0] rdataReg;

    // lane of the byte returning from the RAM this cycle
    assign lane = idx[1:0] - 2'd1;

    assign ram.addr  = addrReg;
    assign ram.we    = (state == memPkg::WRITE);
    assign ram.wbyte = wdataReg[8*idx[1:0] +: 8];

    assign bus.done  = (state == memPkg::FINISH);
    assign bus.rdata = rdataReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= memPkg::IDLE;
        end else begin
            case (state)
                memPkg::IDLE: begin
                    if (bus.en) begin
                        if (bus.op == lsuPkg::STORE) begin
                            state <= memPkg::WRITE;
                        end else begin
                            state <= memPkg::READ;
                        end
                    end
                end
                memPkg::WRITE: begin
                    if (idx == nBytes - 3'd1) begin
                        state <= memPkg::FINISH;
                    end
                end
                // one extra cycle to catch the last returning byte
                memPkg::READ: begin
                    if (idx == nBytes) begin
                        state <= memPkg::FINISH;
                    end
                end
                default: begin
                    state <= memPkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            memPkg::IDLE: begin
                if (bus.en) begin
                    addrReg  <= bus.addr[$bits(memPkg::ramAddr)-1:0];
                    nBytes   <= lsuPkg::lenToBytes(bus.len);
                    wdataReg <= bus.wdata;
                    rdataReg <= '0;
                    idx      <= '0;
                end
            end
            // low byte first
            memPkg::WRITE: begin
                addrReg <= addrReg + 1'b1;
                idx     <= idx + 3'd1;
            end
            memPkg::READ: begin
                if (idx < nBytes) begin
                    addrReg <= addrReg + 1'b1;
                end
                if (idx != '0) begin
                    rdataReg[8*lane +: 8] <= ram.rbyte;
                end
                idx <= idx + 3'd1;
            end
            default: begin
            end
        endcase
    end

endmodule

// File: design/memRequest.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module memRequest (
    input  logic                   clk,
    input  logic                   rst,
    lsReqIf.sink                   issue,
    memBusIf.master                bus,
    output logic                   respValid,
    output logic [`DATA_WIDTH-1:0] respData,
    output logic [`TAG_WIDTH-1:0]  respTag
);
    logic                  occupied;
    logic [`TAG_WIDTH-1:0] tag;
    lsuPkg::memOp          op;

    // also high in the strobe cycle so the queue cannot issue twice
    assign issue.busy = occupied || issue.en;

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied  <= 1'b0;
            bus.en    <= 1'b0;
            respValid <= 1'b0;
        end else begin
            bus.en    <= issue.en;
            respValid <= bus.done;
            if (issue.en) begin
                occupied <= 1'b1;
            end else if (bus.done) begin
                occupied <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue.en) begin
            bus.op    <= issue.op;
            bus.addr  <= issue.addr;
            bus.wdata <= issue.data;
            bus.len   <= issue.len;
            tag       <= issue.tag;
            op        <= issue.op;
        end
        if (bus.done) begin
            respTag <= tag;
            // stores complete with zero data
            if (op == lsuPkg::LOAD) begin
                respData <= bus.rdata;
            end else begin
                respData <= '0;
            end
        end
    end

endmodule

// File: design/reqQueue.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module reqQueue (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   reqValid,
    input  lsuPkg::memOp           reqOp,
    input  logic [`ADDR_WIDTH-1:0] reqAddr,
    input  logic [`DATA_WIDTH-1:0] reqData,
    input  lsuPkg::accessLen       reqLen,
    input  logic [`TAG_WIDTH-1:0]  reqTag,
    output logic                   reqFull,
    lsReqIf.source                 issue
);
    localparam int ptrWidth = $clog2(`QUEUE_DEPTH);
    localparam int countWidth = $clog2(`QUEUE_DEPTH + 1);

    lsuPkg::lsRequest      entries [`QUEUE_DEPTH];
    lsuPkg::lsRequest      head;
    logic [ptrWidth-1:0]   rdPtr;
    logic [ptrWidth-1:0]   wrPtr;
    logic [countWidth-1:0] count;
    logic                  push;
    logic                  pop;

    function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
        if (ptr == ptrWidth'(`QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign reqFull = (count == countWidth'(`QUEUE_DEPTH));
    // requests arriving while full are dropped
    assign push = reqValid && !reqFull;
    assign pop = !issue.busy && (count != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr    <= '0;
            wrPtr    <= '0;
            count    <= '0;
            issue.en <= 1'b0;
        end else begin
            issue.en <= pop;
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= '{op: reqOp, addr: reqAddr, data: reqData,
                                len: reqLen, tag: reqTag};
        end
        // head is presented together with the issue strobe
        if (pop) begin
            head <= entries[rdPtr];
        end
    end

    assign issue.op   = head.op;
    assign issue.addr = head.addr;
    assign issue.data = head.data;
    assign issue.len  = head.len;
    assign issue.tag  = head.tag;

endmodule

// File: design/lsuInterfaces.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

// queue to request stage
interface lsReqIf;
    logic                   en;
    lsuPkg::memOp           op;
    logic [`ADDR_WIDTH-1:0] addr;
    logic [`DATA_WIDTH-1:0] data;
    lsuPkg::accessLen       len;
    logic [`TAG_WIDTH-1:0]  tag;
    logic                   busy;

    modport source (output en, op, addr, data, len, tag, input busy);
    modport sink (input en, op, addr, data, len, tag, output busy);
endinterface

// request stage to memory controller, one operation in flight
interface memBusIf;
    logic                   en;
    lsuPkg::memOp           op;
    logic [`ADDR_WIDTH-1:0] addr;
    logic [`DATA_WIDTH-1:0] wdata;
    lsuPkg::accessLen       len;
    logic                   done;
    logic [`DATA_WIDTH-1:0] rdata;

    modport master (output en, op, addr, wdata, len, input done, rdata);
    modport slave (input en, op, addr, wdata, len, output done, rdata);
endinterface

// controller to byte RAM
interface ramPortIf;
    memPkg::ramAddr addr;
    logic           we;
    logic [7:0]     wbyte;
    // valid one cycle after addr
    logic [7:0]     rbyte;

    modport master (output addr, we, wbyte, input rbyte);
    modport slave (input addr, we, wbyte, output rbyte);
endinterface

// File: design/memPkg.sv
`include "lsu_consts.svh"

package memPkg;

    // controller sequencing states
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        READ   = 2'd1,
        WRITE  = 2'd2,
        FINISH = 2'd3
    } ctrlState;

    // byte address into the RAM, only the low bits of a request address
    typedef logic [$clog2(`RAM_BYTES)-1:0] ramAddr;

endpackage

// File: design/lsuPkg.sv
`include "lsu_consts.svh"

package lsuPkg;

    typedef enum logic {
        LOAD  = 1'b0,
        STORE = 1'b1
    } memOp;

    // 1, 2 or 4 bytes
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } accessLen;

    typedef struct packed {
        memOp                   op;
        logic [`ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] data;
        accessLen               len;
        logic [`TAG_WIDTH-1:0]  tag;
    } lsRequest;

    function automatic logic [2:0] lenToBytes(input accessLen len);
        case (len)
            BYTE:    return 3'd1;
            HALF:    return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

endpackage

// File: design/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// request field widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 32
`define TAG_WIDTH 4

// number of entries in the request queue
`define QUEUE_DEPTH 4

// byte-wide RAM size, addresses wrap on the low bits
`define RAM_BYTES 1024

`endif
